//--- all.f
// package first, then the RTL blocks, the top level and the testbench
rtl/mapPkg.sv
rtl/keyDecode.sv
rtl/scrollExecute.sv
rtl/tileMapRom.sv
rtl/pixelComposer.sv
rtl/colorMapperTop.sv
verif/colorMapperTb.sv

//--- run.sh
#!/bin/sh
# compile the map view and its testbench with Verilator, then run it
# the run exits nonzero when the testbench stops on an error
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module colorMapperTb &&
./obj_dir/VcolorMapperTb &&
echo "simulation completed" ||
{ echo "simulation reported an error"; exit 1; }

//--- map.hex
// tile index per 16x16 tile, 30 columns per line, 20 lines top to bottom
// 1-7 floor, 8 and above walls, border tiles are 9
9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9
9 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 9
9 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 9
9 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 9
9 3 4 5 6 7 1 2 3 4 8 a 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 9
9 5 6 7 1 2 3 4 5 6 8 a 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 9
9 7 1 2 3 4 5 6 7 1 8 a 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 9
9 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 9
9 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 9
9 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 9
9 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 9
9 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 9
9 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 9
9 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 9
9 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 9
9 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 9
9 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 9
9 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 9
9 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 3 4 5 6 7 1 2 9
9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9 9

//--- sprite.hex
// palette index per sprite pixel, two 8-pixel rows per line
// frames in order left, right, up, down, 4 lines each, index 0 is transparent
0 0 0 c c c 0 0 0 0 c f f f c 0
0 c 5 f f f c 0 c 5 5 f f f c 0
0 c 5 f f f c 0 0 0 c f f f c 0
0 0 0 c c c 0 0 0 0 0 6 0 6 0 0
0 0 c c c 0 0 0 0 c f f f c 0 0
0 c f f f 5 c 0 0 c f f f 5 5 c
0 c f f f 5 c 0 0 c f f f c 0 0
0 0 c c c 0 0 0 0 0 6 0 6 0 0 0
0 0 0 c c 0 0 0 0 0 c 5 5 c 0 0
0 c 5 5 5 5 c 0 0 c f f f f c 0
0 c f f f f c 0 0 c f f f f c 0
0 0 c c c c 0 0 0 0 6 0 0 6 0 0
0 0 c c c c 0 0 0 c f f f f c 0
0 c f f f f c 0 0 c f f f f c 0
0 c 5 5 5 5 c 0 0 0 c 5 5 c 0 0
0 0 0 c c 0 0 0 0 0 6 0 0 6 0 0

//--- verif/colorMapperTb.sv
// testbench for the scrolling map view
// drives random pixels and WASD frames into the DUT and checks RGB
// against a camera and pixel model built from map.hex and sprite.hex
`timescale 1ns/1ps

module colorMapperTb;
	import mapPkg::*;

	// ----------------------------------------
	// run length
	localparam int ClkPeriod      = 4;
	localparam int ResetCycles    = 5;
	localparam int PixPerFrame    = 40;
	localparam int CyclesPerFrame = PixPerFrame + 1;
	localparam int StartFrames    = 3;
	localparam int RandomFrames   = 200;
	localparam int ParkPairs      = 250;
	localparam int HoldPairs      = 2;
	localparam int WallRunFrames  = 50;
	localparam int TailFrames     = 40;
	// wall run, one turn up, two pushes right, three steps down
	localparam int TotalFrames    = StartFrames + RandomFrames + 2 * ParkPairs +
	                                2 * HoldPairs + WallRunFrames + 6 + TailFrames;
	localparam int WatchdogNs     = (TotalFrames * CyclesPerFrame + 100) * ClkPeriod;

	// geometry as plain integers
	localparam int WinX0  = int'(ScreenWinX0);
	localparam int WinY0  = int'(ScreenWinY0);
	localparam int WinX1  = WinX0 + int'(ScreenWinW);
	localparam int WinY1  = WinY0 + int'(ScreenWinH);
	localparam int ViewW  = int'(ScreenWinW) / 2;
	localparam int ViewH  = int'(ScreenWinH) / 2;
	localparam int SprX0  = int'(SpriteCenterX) - int'(SpriteHalf);
	localparam int SprY0  = int'(SpriteCenterY) - int'(SpriteHalf);
	localparam int SprX1  = int'(SpriteCenterX) + int'(SpriteHalf);
	localparam int SprY1  = int'(SpriteCenterY) + int'(SpriteHalf);
	localparam int OffX   = int'(SpriteMapOffX);
	localparam int OffY   = int'(SpriteMapOffY);
	localparam int Probe  = int'(ProbeDist);
	localparam int XMin   = int'(CamXMin);
	localparam int XMax   = int'(CamXMax);
	localparam int YMin   = int'(CamYMin);
	localparam int YMax   = int'(CamYMax);
	// first wall column of the block in map.hex
	localparam int WallCol = 10;

	logic       clk;
	logic       Reset;
	logic [7:0] keycode;
	logic       frameTick;
	logic [9:0] DrawX;
	logic [9:0] DrawY;
	logic       displayOn;
	logic [7:0] Red;
	logic [7:0] Green;
	logic [7:0] Blue;

	// model state
	logic [TileIdxW-1:0] mapModel [TilesX*TilesY];
	colorT               spriteModel [256];
	int                  modelCamX;
	int                  modelCamY;
	dirT                 modelFacing;
	integer              seed;
	// predicted RGB, two pixels in flight
	logic [11:0]         expQ [$];

	colorMapperTop uut (
		.clk       (clk),
		.Reset     (Reset),
		.keycode   (keycode),
		.frameTick (frameTick),
		.DrawX     (DrawX),
		.DrawY     (DrawY),
		.displayOn (displayOn),
		.Red       (Red),
		.Green     (Green),
		.Blue      (Blue)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// hard stop if the sequence stalls
	initial begin
		#(WatchdogNs);
		$display("watchdog expired after %0d ns before the test sequence completed", WatchdogNs);
		$display("*** FAILED ***");
		$fatal(1, "timeout");
	end

	// ----------------------------------------
	// error reporting and compares
	task automatic failRun(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkRgb(input logic [7:0] expRed, input logic [7:0] expGreen,
	                        input logic [7:0] expBlue);
		if (Red !== expRed) begin
			failRun($sformatf("MISMATCH Red expected %h got %h", expRed, Red));
		end
		if (Green !== expGreen) begin
			failRun($sformatf("MISMATCH Green expected %h got %h", expGreen, Green));
		end
		if (Blue !== expBlue) begin
			failRun($sformatf("MISMATCH Blue expected %h got %h", expBlue, Blue));
		end
	endtask

	task automatic checkCam(input logic [CamW-1:0] expX, input logic [CamW-1:0] expY);
		if (uut.camX !== expX) begin
			failRun($sformatf("MISMATCH camX expected %h got %h", expX, uut.camX));
		end
		if (uut.camY !== expY) begin
			failRun($sformatf("MISMATCH camY expected %h got %h", expY, uut.camY));
		end
	endtask

	// ----------------------------------------
	// reference model
	function automatic int pickBelow(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [TileIdxW-1:0] mapTile(input int mx, input int my);
		return mapModel[(my / TileSize) * TilesX + mx / TileSize];
	endfunction

	// frame order of sprite.hex
	function automatic int frameOf(input dirT d);
		case (d)
			dirLeft:  return 0;
			dirRight: return 1;
			dirUp:    return 2;
			default:  return 3;
		endcase
	endfunction

	function automatic dirT dirOf(input logic [7:0] key);
		case (key)
			KeyA:    return dirLeft;
			KeyD:    return dirRight;
			KeyW:    return dirUp;
			KeyS:    return dirDown;
			default: return dirNone;
		endcase
	endfunction

	// colour of one screen pixel for the current camera and facing
	function automatic logic [11:0] predictRgb(input int dx, input int dy, input logic disp);
		int    mx;
		int    my;
		colorT idx;
		if (!disp || dx < WinX0 || dx >= WinX1 || dy < WinY0 || dy >= WinY1) begin
			return 12'h000;
		end
		mx = (dx - WinX0) / 2 + modelCamX;
		my = (dy - WinY0) / 2 + modelCamY;
		if (dx >= SprX0 && dx < SprX1 && dy >= SprY0 && dy < SprY1) begin
			idx = spriteModel[frameOf(modelFacing) * 64 + ((dy - SprY0) / 2) * 8 +
			                  (dx - SprX0) / 2];
			if (idx != TransparentIdx) begin
				return Palette[idx];
			end
		end
		return Palette[mapTile(mx, my)];
	endfunction

	// camera step on a frame tick
	task automatic modelStep(input logic [7:0] key);
		dirT  d;
		int   px;
		int   py;
		int   stepX;
		int   stepY;
		logic atEdge;
		d      = dirOf(key);
		px     = modelCamX + OffX;
		py     = modelCamY + OffY;
		stepX  = 0;
		stepY  = 0;
		atEdge = 1'b0;
		case (d)
			dirLeft: begin
				px     = px - Probe;
				stepX  = -1;
				atEdge = (modelCamX == XMin);
			end
			dirRight: begin
				px     = px + Probe;
				stepX  = 1;
				atEdge = (modelCamX == XMax);
			end
			dirUp: begin
				py     = py - Probe;
				stepY  = -1;
				atEdge = (modelCamY == YMin);
			end
			dirDown: begin
				py     = py + Probe;
				stepY  = 1;
				atEdge = (modelCamY == YMax);
			end
			default: begin
				atEdge = 1'b1;
			end
		endcase
		if (d != dirNone) begin
			// facing turns even on a refused step
			modelFacing = d;
			if (!atEdge) begin
				if (mapTile(px, py) < WallTileFirst) begin
					modelCamX = modelCamX + stepX;
					modelCamY = modelCamY + stepY;
				end
			end
		end
	endtask

	// ----------------------------------------
	// stimulus
	function automatic logic [7:0] pickKey();
		case (pickBelow(6))
			0:       return KeyA;
			1:       return KeyD;
			2:       return KeyW;
			3:       return KeyS;
			4:       return 8'h00;
			default: return 8'(pickBelow(256));
		endcase
	endfunction

	// mix of window, sprite box, tile borders and anywhere on screen
	task automatic pickPixel(output logic [9:0] dx, output logic [9:0] dy, output logic disp);
		int kind;
		int px;
		int py;
		int bx;
		int by;
		kind = pickBelow(10);
		px   = WinX0 + pickBelow(WinX1 - WinX0);
		py   = WinY0 + pickBelow(WinY1 - WinY0);
		case (kind)
			0: begin
				px = pickBelow(640);
				py = pickBelow(480);
			end
			1, 2: begin
				// sprite box plus a few pixels around it
				px = SprX0 - 6 + pickBelow(SprX1 - SprX0 + 12);
				py = SprY0 - 6 + pickBelow(SprY1 - SprY0 + 12);
			end
			3: begin
				// either side of a vertical tile border
				bx = ((modelCamX + pickBelow(ViewW)) / TileSize) * TileSize;
				if (pickBelow(2) == 1) begin
					bx = bx - 1;
				end
				if (bx < modelCamX) begin
					bx = modelCamX;
				end
				px = WinX0 + (bx - modelCamX) * 2 + pickBelow(2);
			end
			4: begin
				by = ((modelCamY + pickBelow(ViewH)) / TileSize) * TileSize;
				if (pickBelow(2) == 1) begin
					by = by - 1;
				end
				if (by < modelCamY) begin
					by = modelCamY;
				end
				py = WinY0 + (by - modelCamY) * 2 + pickBelow(2);
			end
			default: begin
				// anywhere inside the window
			end
		endcase
		dx   = 10'(px);
		dy   = 10'(py);
		disp = (pickBelow(8) != 0);
	endtask

	// one clock: drive, predict, then check the pixel from two clocks back
	task automatic stepCycle(input logic [7:0] key, input logic tick);
		logic [9:0]  dx;
		logic [9:0]  dy;
		logic        disp;
		logic [11:0] expRgb;
		pickPixel(dx, dy, disp);
		@(posedge clk);
		keycode   <= key;
		frameTick <= tick;
		DrawX     <= dx;
		DrawY     <= dy;
		displayOn <= disp;
		// pixel sees the camera from before this tick
		expQ.push_back(predictRgb(int'(dx), int'(dy), disp));
		if (tick) begin
			modelStep(key);
		end
		@(negedge clk);
		expRgb = expQ.pop_front();
		checkRgb({expRgb[11:8], 4'h0}, {expRgb[7:4], 4'h0}, {expRgb[3:0], 4'h0});
	endtask

	task automatic runFrame(input logic [7:0] key);
		stepCycle(key, 1'b1);
		repeat (PixPerFrame) begin
			stepCycle(key, 1'b0);
		end
		checkCam(10'(modelCamX), 10'(modelCamY));
	endtask

	// ----------------------------------------
	// test sequence
	initial begin
		seed         = 32'h415d7a54;
		Reset        = 1'b1;
		keycode      = 8'h00;
		frameTick    = 1'b0;
		DrawX        = 10'd0;
		DrawY        = 10'd0;
		displayOn    = 1'b0;
		modelCamX    = int'(CamXReset);
		modelCamY    = int'(CamYReset);
		modelFacing  = dirDown;
		$readmemh("map.hex", mapModel);
		$readmemh("sprite.hex", spriteModel);

		repeat (ResetCycles - 1) @(posedge clk);
		@(negedge clk);
		checkRgb(8'h00, 8'h00, 8'h00);
		checkCam(CamXReset, CamYReset);
		@(posedge clk);
		Reset <= 1'b0;
		// pipeline still holds reset state
		expQ.push_back(12'h000);
		expQ.push_back(12'h000);

		// first frames at the reset camera, sprite facing down
		repeat (StartFrames) runFrame(8'h00);

		// random walk
		repeat (RandomFrames) runFrame(pickKey());

		// up and left until parked in the corner
		repeat (ParkPairs) begin
			runFrame(KeyA);
			runFrame(KeyW);
		end
		checkCam(CamXMin, CamYMin);
		repeat (HoldPairs) begin
			runFrame(KeyA);
			runFrame(KeyW);
		end
		checkCam(CamXMin, CamYMin);

		// right into the wall block, probe stops the camera
		repeat (WallRunFrames) runFrame(KeyD);
		checkCam(10'(WallCol * TileSize - Probe - OffX), CamYMin);
		// turn up at the top edge, then push right against the wall again
		runFrame(KeyW);
		repeat (2) runFrame(KeyD);
		checkCam(10'(WallCol * TileSize - Probe - OffX), CamYMin);
		repeat (3) runFrame(KeyS);

		repeat (TailFrames) runFrame(pickKey());

		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- rtl/colorMapperTop.sv
// top level of the scrolling map view
// keys steer the camera once per frame, the composer draws every clock
`timescale 1ns/1ps

module colorMapperTop (
	input  logic       clk,
	input  logic       Reset,
	input  logic [7:0] keycode,
	input  logic       frameTick,
	input  logic [9:0] DrawX,
	input  logic [9:0] DrawY,
	input  logic       displayOn,
	output logic [7:0] Red,
	output logic [7:0] Green,
	output logic [7:0] Blue
);
	import mapPkg::*;

	dirT                  moveDir;
	dirT                  facing;
	logic [CamW-1:0]      camX;
	logic [CamW-1:0]      camY;
	logic [TileAddrW-1:0] probeAddr;
	logic [TileAddrW-1:0] pixAddr;
	logic [TileIdxW-1:0]  probeTile;
	logic [TileIdxW-1:0]  pixTile;

	// ----------------------------------------
	// decode and camera
	keyDecode uKeyDecode (
		.keycode (keycode),
		.moveDir (moveDir)
	);

	scrollExecute uScrollExecute (
		.clk       (clk),
		.Reset     (Reset),
		.frameTick (frameTick),
		.moveDir   (moveDir),
		.probeTile (probeTile),
		.probeAddr (probeAddr),
		.camX      (camX),
		.camY      (camY),
		.facing    (facing)
	);

	// ----------------------------------------
	// map memory and pixel path
	tileMapRom uTileMapRom (
		.clk       (clk),
		.pixAddr   (pixAddr),
		.probeAddr (probeAddr),
		.pixTile   (pixTile),
		.probeTile (probeTile)
	);

	pixelComposer uPixelComposer (
		.clk       (clk),
		.Reset     (Reset),
		.DrawX     (DrawX),
		.DrawY     (DrawY),
		.displayOn (displayOn),
		.camX      (camX),
		.camY      (camY),
		.facing    (facing),
		.pixTile   (pixTile),
		.pixAddr   (pixAddr),
		.Red       (Red),
		.Green     (Green),
		.Blue      (Blue)
	);

endmodule

//--- rtl/pixelComposer.sv
// two-stage pixel pipeline for the map view
// stage 1 maps the draw position into the map and the sprite box
// stage 2 picks sprite or tile colour through the palette
// RGB follows the sampled draw position by two clocks
`timescale 1ns/1ps

module pixelComposer (
	input  logic                         clk,
	input  logic                         Reset,
	input  logic [9:0]                   DrawX,
	input  logic [9:0]                   DrawY,
	input  logic                         displayOn,
	input  logic [mapPkg::CamW-1:0]      camX,
	input  logic [mapPkg::CamW-1:0]      camY,
	input  mapPkg::dirT                  facing,
	input  logic [mapPkg::TileIdxW-1:0]  pixTile,
	output logic [mapPkg::TileAddrW-1:0] pixAddr,
	output logic [7:0]                   Red,
	output logic [7:0]                   Green,
	output logic [7:0]                   Blue
);
	import mapPkg::*;

	// four 8x8 frames, left right up down
	colorT spriteMem [256];

	logic [CamW-1:0] mapX;
	logic [CamW-1:0] mapY;
	logic [CamW-1:0] sprOffX;
	logic [CamW-1:0] sprOffY;
	logic            inWin;
	logic            inSprite;
	logic [1:0]      frameSel;
	logic [7:0]      sprAddr;

	// stage 1 registers
	logic            winQ;
	logic            sprOnQ;
	logic            dispQ;
	logic [7:0]      sprAddrQ;

	colorT           sprIdx;
	logic [11:0]     rgb;

	initial begin
		$readmemh("sprite.hex", spriteMem);
	end

	// ----------------------------------------
	// stage 1, window and map position
	assign inWin = (DrawX >= ScreenWinX0) && (DrawX < ScreenWinX0 + ScreenWinW) &&
	               (DrawY >= ScreenWinY0) && (DrawY < ScreenWinY0 + ScreenWinH);

	// two screen pixels per map pixel
	assign mapX = ((DrawX - ScreenWinX0) >> 1) + camX;
	assign mapY = ((DrawY - ScreenWinY0) >> 1) + camY;

	// tile read is registered inside the ROM
	// park the address at 0 outside the window
	assign pixAddr = inWin ? tileAddrOf(mapX, mapY) : '0;

	// sprite box, 16x16 screen pixels around the centre
	assign inSprite = (DrawX >= SpriteCenterX - SpriteHalf) &&
	                  (DrawX < SpriteCenterX + SpriteHalf) &&
	                  (DrawY >= SpriteCenterY - SpriteHalf) &&
	                  (DrawY < SpriteCenterY + SpriteHalf);

	assign sprOffX = DrawX - (SpriteCenterX - SpriteHalf);
	assign sprOffY = DrawY - (SpriteCenterY - SpriteHalf);

	// frame order matches sprite.hex
	always_comb begin
		case (facing)
			dirLeft:  frameSel = 2'd0;
			dirRight: frameSel = 2'd1;
			dirUp:    frameSel = 2'd2;
			default:  frameSel = 2'd3;
		endcase
	end

	// frame * 64 + row * 8 + col, row and col halved for 2x
	assign sprAddr = {frameSel, sprOffY[3:1], sprOffX[3:1]};

	always_ff @(posedge clk or posedge Reset) begin
		if (Reset) begin
			winQ   <= 1'b0;
			sprOnQ <= 1'b0;
			dispQ  <= 1'b0;
		end else begin
			winQ   <= inWin;
			sprOnQ <= inSprite;
			dispQ  <= displayOn;
		end
	end

	always_ff @(posedge clk) begin
		sprAddrQ <= sprAddr;
	end

	// ----------------------------------------
	// stage 2, colour select
	assign sprIdx = spriteMem[sprAddrQ];

	// sprite over tile, index 0 lets the tile through
	always_comb begin
		if (!dispQ || !winQ) begin
			rgb = 12'h000;
		end else if (sprOnQ && (sprIdx != TransparentIdx)) begin
			rgb = Palette[sprIdx];
		end else begin
			rgb = Palette[pixTile];
		end
	end

	// 4-bit palette channels widened to 8 bits
	always_ff @(posedge clk or posedge Reset) begin
		if (Reset) begin
			Red   <= 8'h00;
			Green <= 8'h00;
			Blue  <= 8'h00;
		end else begin
			Red   <= {rgb[11:8], 4'b0000};
			Green <= {rgb[7:4], 4'b0000};
			Blue  <= {rgb[3:0], 4'b0000};
		end
	end

endmodule

//--- rtl/tileMapRom.sv
// tile map memory, 30x20 tile indices loaded from map.hex
// pixel port is a registered read for the display pipeline
// probe port reads asynchronously for the collision check
`timescale 1ns/1ps

module tileMapRom (
	input  logic                         clk,
	input  logic [mapPkg::TileAddrW-1:0] pixAddr,
	input  logic [mapPkg::TileAddrW-1:0] probeAddr,
	output logic [mapPkg::TileIdxW-1:0]  pixTile,
	output logic [mapPkg::TileIdxW-1:0]  probeTile
);
	import mapPkg::*;

	// one entry per tile, row-major
	logic [TileIdxW-1:0] tileMem [TilesX*TilesY];

	initial begin
		$readmemh("map.hex", tileMem);
	end

	// ----------------------------------------
	// pixel port
	// one cycle latency, acts as the first pipeline stage of the composer
	always_ff @(posedge clk) begin
		pixTile <= tileMem[pixAddr];
	end

	// ----------------------------------------
	// collision port
	// same cycle, camera logic decides before the frame tick edge
	assign probeTile = tileMem[probeAddr];

endmodule

//--- rtl/scrollExecute.sv
// camera update for the map view, one map pixel per frame tick
// checks the map bounds and the tile just ahead of the sprite
// also holds the sprite facing, which follows every requested move
`timescale 1ns/1ps

module scrollExecute (
	input  logic                         clk,
	input  logic                         Reset,
	input  logic                         frameTick,
	input  mapPkg::dirT                  moveDir,
	input  logic [mapPkg::TileIdxW-1:0]  probeTile,
	output logic [mapPkg::TileAddrW-1:0] probeAddr,
	output logic [mapPkg::CamW-1:0]      camX,
	output logic [mapPkg::CamW-1:0]      camY,
	output mapPkg::dirT                  facing
);
	import mapPkg::*;

	logic [CamW-1:0] centreX;
	logic [CamW-1:0] centreY;
	logic [CamW-1:0] probeX;
	logic [CamW-1:0] probeY;
	logic            atEdge;
	logic            isWall;
	logic            blocked;

	// ----------------------------------------
	// collision probe
	// sprite centre in map pixels
	assign centreX = camX + SpriteMapOffX;
	assign centreY = camY + SpriteMapOffY;

	// probe point and bound check per direction
	always_comb begin
		probeX = centreX;
		probeY = centreY;
		atEdge = 1'b0;
		case (moveDir)
			dirLeft: begin
				probeX = centreX - ProbeDist;
				atEdge = (camX == CamXMin);
			end
			dirRight: begin
				probeX = centreX + ProbeDist;
				atEdge = (camX == CamXMax);
			end
			dirUp: begin
				probeY = centreY - ProbeDist;
				atEdge = (camY == CamYMin);
			end
			dirDown: begin
				probeY = centreY + ProbeDist;
				atEdge = (camY == CamYMax);
			end
			default: begin
				atEdge = 1'b0;
			end
		endcase
	end

	// probe never leaves the map, the centre sits well inside
	assign probeAddr = tileAddrOf(probeX, probeY);

	// upper half of the tile set is solid
	assign isWall  = (probeTile >= WallTileFirst);
	assign blocked = atEdge | isWall;

	// ----------------------------------------
	// camera and facing registers
	always_ff @(posedge clk or posedge Reset) begin
		if (Reset) begin
			camX   <= CamXReset;
			camY   <= CamYReset;
			facing <= dirDown;
		end else if (frameTick) begin
			// turn even when the step is refused
			if (moveDir != dirNone) begin
				facing <= moveDir;
			end
			if (!blocked) begin
				case (moveDir)
					dirLeft: begin
						camX <= camX - 1'b1;
					end
					dirRight: begin
						camX <= camX + 1'b1;
					end
					dirUp: begin
						camY <= camY - 1'b1;
					end
					dirDown: begin
						camY <= camY + 1'b1;
					end
					default: begin
						camX <= camX;
					end
				endcase
			end
		end
	end

endmodule

//--- rtl/keyDecode.sv
// keyboard decode stage of the map view
// turns the raw USB keycode into a movement direction, combinational
`timescale 1ns/1ps

module keyDecode (
	input  logic [7:0]  keycode,
	output mapPkg::dirT moveDir
);
	import mapPkg::*;

	// ----------------------------------------
	// WASD lookup
	// only single keys move the camera
	always_comb begin
		case (keycode)
			KeyA: begin
				moveDir = dirLeft;
			end
			KeyD: begin
				moveDir = dirRight;
			end
			KeyW: begin
				moveDir = dirUp;
			end
			KeyS: begin
				moveDir = dirDown;
			end
			// anything else, including no key
			default: begin
				moveDir = dirNone;
			end
		endcase
	end

endmodule

//--- rtl/mapPkg.sv
// shared geometry, palette and direction types for the tiled map view
// imported by every RTL block of the scrolling map path
// all screen coordinates are VGA pixels, map coordinates are map pixels
package mapPkg;

	// ----------------------------------------
	// coordinate and index widths
	localparam int CamW      = 10;
	localparam int TileIdxW  = 4;
	localparam int TileAddrW = 10;

	// screen window, map shown at 2x
	localparam logic [CamW-1:0] ScreenWinX0 = 10'd80;
	localparam logic [CamW-1:0] ScreenWinY0 = 10'd80;
	localparam logic [CamW-1:0] ScreenWinW  = 10'd480;
	localparam logic [CamW-1:0] ScreenWinH  = 10'd320;

	// map and tiles
	localparam logic [CamW-1:0] MapW     = 10'd480;
	localparam logic [CamW-1:0] MapH     = 10'd320;
	localparam int              TileSize = 16;
	localparam int              TilesX   = MapW / TileSize;
	localparam int              TilesY   = MapH / TileSize;

	// camera is the top-left map pixel of the visible 240x160 region
	localparam logic [CamW-1:0] CamXMin   = 10'd0;
	localparam logic [CamW-1:0] CamXMax   = MapW - ScreenWinW / 2;
	localparam logic [CamW-1:0] CamYMin   = 10'd0;
	localparam logic [CamW-1:0] CamYMax   = MapH - ScreenWinH / 2;
	localparam logic [CamW-1:0] CamXReset = 10'd16;
	localparam logic [CamW-1:0] CamYReset = 10'd0;

	// player sprite, fixed at screen centre, 8x8 frames drawn 16x16
	localparam logic [CamW-1:0] SpriteCenterX = 10'd320;
	localparam logic [CamW-1:0] SpriteCenterY = 10'd240;
	localparam logic [CamW-1:0] SpriteHalf    = 10'd8;
	localparam logic [CamW-1:0] SpriteMapOffX = (SpriteCenterX - ScreenWinX0) / 2;
	localparam logic [CamW-1:0] SpriteMapOffY = (SpriteCenterY - ScreenWinY0) / 2;

	// collision
	localparam logic [CamW-1:0]     ProbeDist     = 10'd4;
	localparam logic [TileIdxW-1:0] WallTileFirst = 4'd8;

	// ----------------------------------------
	// colours and keys
	typedef logic [3:0] colorT;

	localparam colorT TransparentIdx = 4'd0;

	// 12-bit RGB, red in the top nibble
	localparam logic [11:0] Palette [16] = '{
		12'h000, 12'h4A3, 12'h6C4, 12'hDC8, 12'hEEB, 12'hF66, 12'hFC6, 12'h36A,
		12'h777, 12'h555, 12'h853, 12'h642, 12'h24B, 12'h146, 12'hAAA, 12'hFFF
	};

	localparam logic [7:0] KeyA = 8'h04;
	localparam logic [7:0] KeyD = 8'h07;
	localparam logic [7:0] KeyW = 8'h1A;
	localparam logic [7:0] KeyS = 8'h16;

	typedef enum logic [2:0] {
		dirNone,
		dirLeft,
		dirRight,
		dirUp,
		dirDown
	} dirT;

	// row-major tile address of a map pixel
	function automatic logic [TileAddrW-1:0] tileAddrOf(input logic [CamW-1:0] px,
	                                                    input logic [CamW-1:0] py);
		logic [TileAddrW-1:0] col;
		logic [TileAddrW-1:0] row;
		col = TileAddrW'(px / TileSize);
		row = TileAddrW'(py / TileSize);
		return TileAddrW'(row * TilesX) + col;
	endfunction

endpackage
